/* tb.f */
+incdir+test
rtl/md_pkg.sv
rtl/md_op_if.sv
rtl/md_decode.sv
rtl/md_mult.sv
rtl/md_div.sv
rtl/md_result.sv
rtl/md_unit.sv
test/tb_md_unit.sv

/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_md_unit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* test/md_tb_model.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32M reference model and operand LFSR for the testbench
// Included inside the testbench module, which imports md_pkg
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MD_TB_MODEL_SVH
`define MD_TB_MODEL_SVH

// Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 32'h8020_0003;
  end
  return next;
endfunction

// Upper word of the 64-bit product, each operand extended by its own sign mode
function automatic logic [31:0] mul_high(input logic [31:0] a, input logic [31:0] b,
                                         input logic a_signed, input logic b_signed);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] prod;
  ext_a = {{32{a_signed & a[31]}}, a};
  ext_b = {{32{b_signed & b[31]}}, b};
  prod  = ext_a * ext_b;
  return prod[63:32];
endfunction

// Quotient rounds toward zero; a zero divisor gives all ones
function automatic logic [31:0] quotient(input logic [31:0] a, input logic [31:0] b,
                                         input logic is_signed);
  logic signed [63:0] num;
  logic signed [63:0] den;
  logic signed [63:0] quo;
  if (b == '0) begin
    return '1;
  end
  num = {{32{is_signed & a[31]}}, a};
  den = {{32{is_signed & b[31]}}, b};
  // 64-bit math keeps -2^31 / -1 from overflowing
  quo = num / den;
  return quo[31:0];
endfunction

// Remainder takes the sign of the dividend; a zero divisor gives a
function automatic logic [31:0] remainder(input logic [31:0] a, input logic [31:0] b,
                                          input logic is_signed);
  logic signed [63:0] num;
  logic signed [63:0] den;
  logic signed [63:0] rem;
  if (b == '0) begin
    return a;
  end
  num = {{32{is_signed & a[31]}}, a};
  den = {{32{is_signed & b[31]}}, b};
  rem = num % den;
  return rem[31:0];
endfunction

function automatic logic [31:0] expected_result(input md_op_e op, input logic [31:0] a,
                                                input logic [31:0] b);
  case (op)
    MD_OP_MUL:    return a * b;
    MD_OP_MULH:   return mul_high(a, b, 1'b1, 1'b1);
    MD_OP_MULHSU: return mul_high(a, b, 1'b1, 1'b0);
    MD_OP_MULHU:  return mul_high(a, b, 1'b0, 1'b0);
    MD_OP_DIV:    return quotient(a, b, 1'b1);
    MD_OP_DIVU:   return quotient(a, b, 1'b0);
    MD_OP_REM:    return remainder(a, b, 1'b1);
    default:      return remainder(a, b, 1'b0);
  endcase
endfunction

`endif

/* test/tb_md_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32M multiply/divide unit
// Results are checked by assertions against the included reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_md_unit
  import md_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 100;
  localparam int RANDOM_RUNS    = 24;

  logic               clk_i;
  logic               rst_ni;
  logic               start_i;
  md_op_e             op_i;
  logic [MD_XLEN-1:0] op_a_i;
  logic [MD_XLEN-1:0] op_b_i;
  logic               busy_o;
  logic [MD_XLEN-1:0] result_o;
  logic               valid_o;

  logic [31:0] lfsr_q;
  logic [31:0] exp_result;
  string       exp_name;
  int          errors    = 0;
  int          issued    = 0;
  int          valid_cnt = 0;

  `include "md_tb_model.svh"

  md_unit UUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .busy_o   (busy_o),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (valid_o) begin
      valid_cnt <= valid_cnt + 1;
    end
  end

  // Every result must match the model value of the running operation
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_o |-> (result_o == exp_result))
  else begin
    errors++;
    $display("Mismatch %s: expected %08h, actual %08h", exp_name, exp_result,
             $sampled(result_o));
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_o |=> (!valid_o && !busy_o))
  else begin
    errors++;
    $display("valid_o stayed high for two cycles or busy_o did not drop after it");
  end

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Samples on the falling edge, returns on the rising edge after valid_o
  task automatic wait_valid();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      seen = valid_o;
      cycles++;
    end
    if (!seen) begin
      errors++;
      $display("Timeout: no valid_o within %0d cycles for %s", TIMEOUT_CYCLES, exp_name);
    end
    @(posedge clk_i);
  endtask

  task automatic run_op(input md_op_e op, input logic [31:0] a, input logic [31:0] b);
    start_i <= 1'b1;
    op_i    <= op;
    op_a_i  <= a;
    op_b_i  <= b;
    @(posedge clk_i);
    start_i    <= 1'b0;
    exp_result  = expected_result(op, a, b);
    exp_name    = $sformatf("%s a=%08h b=%08h", op.name(), a, b);
    issued++;
    wait_valid();
  endtask

  // Second start lands while the divider is busy and must leave no trace
  task automatic ignore_busy_start();
    start_i <= 1'b1;
    op_i    <= MD_OP_DIV;
    op_a_i  <= 32'h7654_3210;
    op_b_i  <= 32'hffff_ff9c;
    @(posedge clk_i);
    start_i    <= 1'b0;
    exp_result  = expected_result(MD_OP_DIV, 32'h7654_3210, 32'hffff_ff9c);
    exp_name    = "DIV with ignored start";
    issued++;
    repeat (3) @(posedge clk_i);
    start_i <= 1'b1;
    op_i    <= MD_OP_MUL;
    op_a_i  <= 32'h0000_0003;
    op_b_i  <= 32'h0000_0005;
    @(posedge clk_i);
    start_i <= 1'b0;
    wait_valid();
    repeat (50) @(posedge clk_i);
    @(negedge clk_i);
    assert (valid_cnt == issued)
    else begin
      errors++;
      $display("A start_i during busy_o produced an extra result");
    end
    @(posedge clk_i);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] width;
    logic [31:0] neg;
    rst_ni  <= 1'b0;
    start_i <= 1'b0;
    op_i    <= MD_OP_MUL;
    op_a_i  <= '0;
    op_b_i  <= '0;
    lfsr_q   = 32'h8358_29c2;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!valid_o && !busy_o && result_o == '0)
    else begin
      errors++;
      $display("Outputs are not idle after reset");
    end
    @(posedge clk_i);

    run_op(MD_OP_MUL, 32'h8000_0000, 32'h8000_0000);
    run_op(MD_OP_MULH, 32'h8000_0000, 32'h8000_0000);
    run_op(MD_OP_MULHSU, 32'h8000_0000, 32'h8000_0000);
    run_op(MD_OP_MULHU, 32'h8000_0000, 32'h8000_0000);
    run_op(MD_OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op(MD_OP_REM, 32'h8000_0000, 32'hffff_ffff);

    // Division by zero on all four divide operations
    for (int k = 4; k < 8; k++) begin
      take_bits(32, a);
      run_op(md_op_e'(k[2:0]), a, '0);
    end

    // Divisor width varies so quotients cover a wide range
    for (int i = 0; i < RANDOM_RUNS; i++) begin
      for (int k = 0; k < 8; k++) begin
        take_bits(32, a);
        take_bits(5, width);
        take_bits(width + 1, b);
        take_bits(1, neg);
        if (neg[0]) begin
          b = -b;
        end
        if (k >= 4 && b == '0) begin
          b = 32'd1;
        end
        run_op(md_op_e'(k[2:0]), a, b);
      end
    end

    ignore_busy_start();

    @(negedge clk_i);
    assert (valid_cnt == issued)
    else begin
      errors++;
      $display("Saw %0d results for %0d accepted operations", valid_cnt, issued);
    end
    $display("Closing report: %0d errors over %0d operations", errors, issued);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/md_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32M multiply/divide unit top level
// start_i is a strobe accepted only while busy_o is low; no back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module md_unit
  import md_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire md_op_e             op_i,
  input  wire logic [MD_XLEN-1:0] op_a_i,
  input  wire logic [MD_XLEN-1:0] op_b_i,
  output logic                    busy_o,
  output logic [MD_XLEN-1:0]      result_o,
  output logic                    valid_o
);

  logic               mult_done;
  logic [MD_XLEN-1:0] mult_result;
  logic               div_done;
  logic [MD_XLEN-1:0] div_result;

  md_op_if op_if ();

  md_decode u_decode (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .op_i    (op_i),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .busy_i  (busy_o),
    .op_o    (op_if)
  );

  md_mult u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .op_i     (op_if),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  md_div u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .op_i     (op_if),
    .done_o   (div_done),
    .result_o (div_result)
  );

  md_result u_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .go_i          (op_if.go),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .div_done_i    (div_done),
    .div_result_i  (div_result),
    .busy_o        (busy_o),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

endmodule

`default_nettype wire

/* rtl/md_result.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result register, valid strobe and busy tracking
// valid_o follows a done by one cycle; busy drops the cycle after valid_o
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module md_result
  import md_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               go_i,
  input  wire logic               mult_done_i,
  input  wire logic [MD_XLEN-1:0] mult_result_i,
  input  wire logic               div_done_i,
  input  wire logic [MD_XLEN-1:0] div_result_i,
  output logic                    busy_o,
  output logic [MD_XLEN-1:0]      result_o,
  output logic                    valid_o
);

  logic busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= mult_done_i | div_done_i;
      if (mult_done_i) begin
        result_o <= mult_result_i;
      end else if (div_done_i) begin
        result_o <= div_result_i;
      end
      // Clears once the valid strobe has been seen
      if (go_i) begin
        busy_q <= 1'b1;
      end else if (valid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Go cycle already counts as busy
  assign busy_o = busy_q | go_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(mult_done_i && div_done_i));

endmodule

`default_nettype wire

/* rtl/md_div.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Long divider with its own subtractor
// Done follows go by 37 cycles, or by 2 for a zero divisor
// Division by zero gives all ones (DIV/DIVU) or operand a (REM/REMU)
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module md_div
  import md_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  md_op_if.exec                    op_i,
  output logic                     done_o,
  output logic [MD_XLEN-1:0]       result_o
);

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

  div_state_e          state_q;
  div_state_e          state_d;
  logic [MD_CNT_W-1:0] cnt_q;
  logic [MD_CNT_W-1:0] cnt_d;
  logic                done_q;
  logic                start;
  logic                is_div;
  logic                sign_a;
  logic                sign_b;
  logic                div_change_sign;
  logic                rem_change_sign;
  logic [MD_XLEN-1:0]  sub_a;
  logic [MD_XLEN-1:0]  sub_b;
  logic [MD_XLEN:0]    sub_res;
  logic                ge;
  logic [MD_XLEN-1:0]  one_shift;
  logic [MD_XLEN-1:0]  next_rem;
  logic [MD_XLEN-1:0]  next_quot;
  logic [MD_XLEN-1:0]  numer_q;
  logic [MD_XLEN-1:0]  numer_d;
  logic [MD_XLEN-1:0]  denom_q;
  logic [MD_XLEN-1:0]  denom_d;
  logic [MD_XLEN-1:0]  quot_q;
  logic [MD_XLEN-1:0]  quot_d;
  md_imd_u             imd_q;
  md_imd_u             imd_d;

  assign is_div = (op_i.op_class == MD_DIV);
  assign start  = op_i.go & (is_div | (op_i.op_class == MD_REM));

  assign sign_a          = op_i.signed_mode[0] & op_i.op_a[MD_XLEN-1];
  assign sign_b          = op_i.signed_mode[1] & op_i.op_b[MD_XLEN-1];
  assign div_change_sign = sign_a ^ sign_b;
  assign rem_change_sign = sign_a;

  // Borrow out of the 33-bit subtract means sub_a < sub_b
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  assign ge      = ~sub_res[MD_XLEN];

  assign one_shift = {{(MD_XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = ge ? sub_res[MD_XLEN-1:0] : imd_q.div.word;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    imd_d   = imd_q;
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    sub_a   = '0;
    sub_b   = op_i.op_b;

    unique case (state_q)
      DIV_IDLE: begin
        if (start) begin
          imd_d.div.guard = 2'b00;
          imd_d.div.word  = is_div ? '1 : op_i.op_a;
          state_d         = op_i.b_zero ? DIV_FINISH : DIV_ABS_A;
        end
      end
      DIV_ABS_A: begin
        sub_b   = op_i.op_a;
        numer_d = sign_a ? sub_res[MD_XLEN-1:0] : op_i.op_a;
        quot_d  = '0;
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        denom_d        = sign_b ? sub_res[MD_XLEN-1:0] : op_i.op_b;
        imd_d.div.word = {{(MD_XLEN-1){1'b0}}, numer_q[MD_XLEN-1]};
        cnt_d          = MD_CNT_W'(MD_XLEN - 1);
        state_d        = DIV_COMP;
      end
      DIV_COMP: begin
        sub_a          = imd_q.div.word;
        sub_b          = denom_q;
        cnt_d          = cnt_q - 1'b1;
        // Shift in the next dividend bit
        imd_d.div.word = {next_rem[MD_XLEN-2:0], numer_q[cnt_d]};
        quot_d         = next_quot;
        state_d        = (cnt_q == MD_CNT_W'(1)) ? DIV_LAST : DIV_COMP;
      end
      DIV_LAST: begin
        sub_a          = imd_q.div.word;
        sub_b          = denom_q;
        imd_d.div.word = is_div ? next_quot : next_rem;
        state_d        = DIV_CHANGE_SIGN;
      end
      DIV_CHANGE_SIGN: begin
        sub_b = imd_q.div.word;
        if (is_div ? div_change_sign : rem_change_sign) begin
          imd_d.div.word = sub_res[MD_XLEN-1:0];
        end
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        state_d = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= (state_q == DIV_FINISH);
    end
  end

  always_ff @(posedge clk_i) begin
    imd_q   <= imd_d;
    numer_q <= numer_d;
    denom_q <= denom_d;
    quot_q  <= quot_d;
  end

  // Result word is held in the partial register through the done cycle
  assign done_o   = done_q;
  assign result_o = imd_q.div.word;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST,
                    DIV_CHANGE_SIGN, DIV_FINISH});

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == DIV_COMP) |-> (cnt_q != '0));

endmodule

`default_nettype wire

/* rtl/md_mult.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle multiplier on one 17x17 signed MAC kernel
// MUL completes in 3 cycles after go, the high variants in 4
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module md_mult
  import md_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  md_op_if.exec                    op_i,
  output logic                     done_o,
  output logic [MD_XLEN-1:0]       result_o
);

  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic               active_q;
  logic               start;
  logic               is_mull;
  logic               signed_mult;
  logic [MD_HALF-1:0] mac_a;
  logic [MD_HALF-1:0] mac_b;
  logic               sign_a;
  logic               sign_b;
  logic [33:0]        accum;
  logic signed [33:0] mac_res;
  md_imd_u            imd_q;
  md_imd_u            imd_d;

  assign is_mull     = (op_i.op_class == MD_MULL);
  assign start       = op_i.go & (is_mull | (op_i.op_class == MD_MULH));
  assign signed_mult = (op_i.signed_mode != 2'b00);

  // Single kernel with a 34-bit accumulate
  assign mac_res = $signed({sign_a, mac_a}) * $signed({sign_b, mac_b}) + $signed(accum);

  always_comb begin
    mac_a    = op_i.op_a[MD_HALF-1:0];
    mac_b    = op_i.op_b[MD_HALF-1:0];
    sign_a   = 1'b0;
    sign_b   = 1'b0;
    accum    = '0;
    imd_d    = mac_res;
    state_d  = state_q;
    done_o   = 1'b0;
    result_o = mac_res[MD_XLEN-1:0];

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end
      ALBH: begin
        mac_b  = op_i.op_b[MD_XLEN-1:MD_HALF];
        sign_b = op_i.signed_mode[1] & op_i.op_b[MD_XLEN-1];
        accum  = {18'b0, imd_q.mul.hi};
        if (is_mull) begin
          imd_d = {2'b00, mac_res[MD_HALF-1:0], imd_q.mul.lo};
        end
        state_d = AHBL;
      end
      AHBL: begin
        mac_a  = op_i.op_a[MD_XLEN-1:MD_HALF];
        sign_a = op_i.signed_mode[0] & op_i.op_a[MD_XLEN-1];
        if (is_mull) begin
          accum    = {18'b0, imd_q.mul.hi};
          result_o = {mac_res[MD_HALF-1:0], imd_q.mul.lo};
          done_o   = active_q;
          state_d  = ALBL;
        end else begin
          accum   = imd_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mac_a  = op_i.op_a[MD_XLEN-1:MD_HALF];
        mac_b  = op_i.op_b[MD_XLEN-1:MD_HALF];
        sign_a = op_i.signed_mode[0] & op_i.op_a[MD_XLEN-1];
        sign_b = op_i.signed_mode[1] & op_i.op_b[MD_XLEN-1];
        // Accumulator moves down by a half-word, sign-extended
        accum   = {{16{signed_mult & imd_q.mul.guard[1]}}, imd_q.mul.guard, imd_q.mul.hi};
        done_o  = active_q;
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      state_q  <= ALBL;
    end else if (start) begin
      active_q <= 1'b1;
      state_q  <= ALBL;
    end else if (active_q) begin
      state_q <= state_d;
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q) begin
      imd_q <= imd_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q));

endmodule

`default_nettype wire

/* rtl/md_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation decode and operand capture
// A start while busy_i is high is dropped; go follows an accept by 1 cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module md_decode
  import md_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire md_op_e             op_i,
  input  wire logic [MD_XLEN-1:0] op_a_i,
  input  wire logic [MD_XLEN-1:0] op_b_i,
  input  wire logic               busy_i,
  md_op_if.decoder                op_o
);

  logic               accept;
  logic               go_q;
  md_class_e          class_d;
  md_class_e          class_q;
  logic [1:0]         smode_d;
  logic [1:0]         smode_q;
  logic               b_zero_q;
  logic [MD_XLEN-1:0] op_a_q;
  logic [MD_XLEN-1:0] op_b_q;

  assign accept = start_i & ~busy_i;

  always_comb begin
    unique case (op_i)
      MD_OP_MUL:    begin class_d = MD_MULL; smode_d = 2'b00; end
      MD_OP_MULH:   begin class_d = MD_MULH; smode_d = 2'b11; end
      MD_OP_MULHSU: begin class_d = MD_MULH; smode_d = 2'b01; end
      MD_OP_MULHU:  begin class_d = MD_MULH; smode_d = 2'b00; end
      MD_OP_DIV:    begin class_d = MD_DIV;  smode_d = 2'b11; end
      MD_OP_DIVU:   begin class_d = MD_DIV;  smode_d = 2'b00; end
      MD_OP_REM:    begin class_d = MD_REM;  smode_d = 2'b11; end
      MD_OP_REMU:   begin class_d = MD_REM;  smode_d = 2'b00; end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      go_q     <= 1'b0;
      class_q  <= MD_MULL;
      smode_q  <= 2'b00;
      b_zero_q <= 1'b0;
    end else begin
      go_q <= accept;
      if (accept) begin
        class_q  <= class_d;
        smode_q  <= smode_d;
        b_zero_q <= (op_b_i == '0);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  assign op_o.go          = go_q;
  assign op_o.op_class    = class_q;
  assign op_o.signed_mode = smode_q;
  assign op_o.op_a        = op_a_q;
  assign op_o.op_b        = op_b_q;
  assign op_o.b_zero      = b_zero_q;

  // Busy feedback must already block a second accept in the go cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    go_q |=> !go_q);

endmodule

`default_nettype wire

/* rtl/md_op_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded operation from decode to the execute modules
// All fields stay stable from go until the operation completes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface md_op_if
  import md_pkg::*;
();

  logic               go;
  md_class_e          op_class;
  // Bit 0 marks operand a as signed, bit 1 operand b
  logic [1:0]         signed_mode;
  logic [MD_XLEN-1:0] op_a;
  logic [MD_XLEN-1:0] op_b;
  logic               b_zero;

  modport decoder (output go, op_class, signed_mode, op_a, op_b, b_zero);

  modport exec (input go, op_class, signed_mode, op_a, op_b, b_zero);

endinterface

`default_nettype wire

/* rtl/md_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the RV32M multiply/divide unit
// Operation codes follow funct3 order; width is fixed at 32 bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package md_pkg;

  localparam int unsigned MD_XLEN  = 32;
  localparam int unsigned MD_HALF  = 16;
  localparam int unsigned MD_CNT_W = 5;

  // M-extension operations in funct3 order
  typedef enum logic [2:0] {
    MD_OP_MUL    = 3'd0,
    MD_OP_MULH   = 3'd1,
    MD_OP_MULHSU = 3'd2,
    MD_OP_MULHU  = 3'd3,
    MD_OP_DIV    = 3'd4,
    MD_OP_DIVU   = 3'd5,
    MD_OP_REM    = 3'd6,
    MD_OP_REMU   = 3'd7
  } md_op_e;

  // Result class seen by the execute modules
  typedef enum logic [1:0] {
    MD_MULL = 2'd0,
    MD_MULH = 2'd1,
    MD_DIV  = 2'd2,
    MD_REM  = 2'd3
  } md_class_e;

  // Partial-result word, split in half-words by the multiplier
  typedef struct packed {
    logic [1:0]         guard;
    logic [MD_HALF-1:0] hi;
    logic [MD_HALF-1:0] lo;
  } md_imd_mul_t;

  typedef struct packed {
    logic [1:0]         guard;
    logic [MD_XLEN-1:0] word;
  } md_imd_div_t;

  typedef union packed {
    md_imd_mul_t mul;
    md_imd_div_t div;
  } md_imd_u;

endpackage

`default_nettype wire
